//--- source/rc6_pkg.sv
// RC6-32/20 shared definitions
// Direction, register map and key schedule state enums, constants, word functions

package rc6_pkg;

	// Cipher direction stored in CTRL bit 2
	typedef enum logic {
		DIR_DECRYPT = 1'b0,
		DIR_ENCRYPT = 1'b1
	} rc6_dir_e;

	// APB word offsets
	typedef enum logic [7:0] {
		REG_CTRL   = 8'h00,
		REG_STATUS = 8'h04,
		REG_KEY0   = 8'h10,
		REG_KEY1   = 8'h14,
		REG_KEY2   = 8'h18,
		REG_KEY3   = 8'h1C,
		REG_KEY4   = 8'h20,
		REG_KEY5   = 8'h24,
		REG_KEY6   = 8'h28,
		REG_KEY7   = 8'h2C,
		REG_DIN0   = 8'h30,
		REG_DIN1   = 8'h34,
		REG_DIN2   = 8'h38,
		REG_DIN3   = 8'h3C,
		REG_DOUT0  = 8'h40,
		REG_DOUT1  = 8'h44,
		REG_DOUT2  = 8'h48,
		REG_DOUT3  = 8'h4C
	} rc6_reg_e;

	// Key schedule FSM
	typedef enum logic [1:0] {
		KS_IDLE,
		KS_MIX,
		KS_READY
	} ks_state_e;

	localparam int NUM_ROUNDS  = 20;
	localparam int NUM_SUBKEYS = 2 * NUM_ROUNDS + 4;

	// Odd(e - 2) and Odd(phi - 1) scaled to 32 bits
	localparam logic [31:0] RC6_P32 = 32'hB7E1_5163;
	localparam logic [31:0] RC6_Q32 = 32'h9E37_79B9;

	// Rotate left by an amount mod 32
	function automatic logic [31:0] rc6_rol(input logic [31:0] d, input logic [4:0] n);
		logic [63:0] dd;
		dd = {d, d} << n;
		return dd[63:32];
	endfunction

	// Byte order reversal between bus words and cipher words
	function automatic logic [31:0] rc6_byteswap(input logic [31:0] d);
		return {d[7:0], d[15:8], d[23:16], d[31:24]};
	endfunction

endpackage

//--- source/rc6_apb_regs.sv
// APB register stage of the RC6 peripheral
// Key, data, control and status registers, start checks, error response, IRQ

module rc6_apb_regs #(
	parameter int KEY_WORDS = 4
) (
	input  logic                     i_clk,
	input  logic                     i_rst,
	// APB slave
	input  logic                     i_psel,
	input  logic                     i_penable,
	input  logic                     i_pwrite,
	input  logic [7:0]               i_paddr,
	input  logic [31:0]              i_pwdata,
	output logic [31:0]              o_prdata,
	output logic                     o_pready,
	output logic                     o_pslverr,
	output logic                     o_irq,
	// Key schedule stage
	output logic                     o_ks_start,
	output logic [32*KEY_WORDS-1:0]  o_user_key,
	input  logic                     i_key_ready,
	// Round stage
	output logic                     o_din_en,
	output logic [127:0]             o_din,
	output rc6_pkg::rc6_dir_e        o_dir,
	input  logic [127:0]             i_dout,
	input  logic                     i_dout_en
);

	localparam int KIW = (KEY_WORDS > 1) ? $clog2(KEY_WORDS) : 1;

	rc6_pkg::rc6_reg_e reg_sel;
	logic              access;
	logic              wr_en;
	logic              rd_status;
	logic              addr_ok;
	logic              err;
	logic [31:0]       prdata;
	logic [7:0]        key_off;
	logic [2:0]        key_idx;
	logic              key_hit;
	logic              ks_running;
	logic              key_ok;
	logic              r_ks_run;
	logic              r_busy;
	logic              r_done;
	logic [31:0]       r_key [KEY_WORDS];
	logic [31:0]       r_din [4];
	logic [127:0]      r_dout;

	// ------------------------------------------------------------
	// Address decode
	// ------------------------------------------------------------
	assign reg_sel = rc6_pkg::rc6_reg_e'(i_paddr);
	assign access  = i_psel & i_penable;
	assign key_off = i_paddr - 8'(rc6_pkg::REG_KEY0);
	assign key_idx = key_off[4:2];
	// Only the first KEY_WORDS key slots exist
	assign key_hit = (int'(key_idx) < KEY_WORDS);

	// Expansion counts as running from the start pulse until key_ready returns
	assign ks_running = o_ks_start | r_ks_run;
	assign key_ok     = i_key_ready & ~ks_running;

	always_comb begin
		addr_ok = 1'b1;
		prdata  = '0;
		case (reg_sel)
			rc6_pkg::REG_CTRL:
				prdata = {29'd0, o_dir, 2'b00};
			rc6_pkg::REG_STATUS:
				prdata = {29'd0, r_done, r_busy, key_ok};
			rc6_pkg::REG_KEY0, rc6_pkg::REG_KEY1, rc6_pkg::REG_KEY2, rc6_pkg::REG_KEY3,
			rc6_pkg::REG_KEY4, rc6_pkg::REG_KEY5, rc6_pkg::REG_KEY6, rc6_pkg::REG_KEY7: begin
				addr_ok = key_hit;
				if (key_hit)
					prdata = r_key[key_idx[KIW-1:0]];
			end
			rc6_pkg::REG_DIN0, rc6_pkg::REG_DIN1, rc6_pkg::REG_DIN2, rc6_pkg::REG_DIN3:
				prdata = r_din[i_paddr[3:2]];
			// DOUT0 is the most significant word
			rc6_pkg::REG_DOUT0, rc6_pkg::REG_DOUT1, rc6_pkg::REG_DOUT2, rc6_pkg::REG_DOUT3:
				prdata = r_dout[32*(3-i_paddr[3:2]) +: 32];
			default:
				addr_ok = 1'b0;
		endcase
	end

	// A refused access changes nothing
	always_comb begin
		err = ~addr_ok;
		if (addr_ok && i_pwrite) begin
			case (reg_sel)
				rc6_pkg::REG_STATUS,
				rc6_pkg::REG_DOUT0, rc6_pkg::REG_DOUT1, rc6_pkg::REG_DOUT2, rc6_pkg::REG_DOUT3:
					err = 1'b1;
				rc6_pkg::REG_CTRL: begin
					// Both starts at once would collide downstream
					if (i_pwdata[0] && i_pwdata[1])
						err = 1'b1;
					else if (i_pwdata[1] && (r_busy || !key_ok))
						err = 1'b1;
					else if (i_pwdata[0] && (r_busy || ks_running))
						err = 1'b1;
				end
				default: ;
			endcase
		end
	end

	assign wr_en     = access & i_pwrite & ~err;
	assign rd_status = access & ~i_pwrite & (reg_sel == rc6_pkg::REG_STATUS);

	assign o_prdata  = (access && !i_pwrite) ? prdata : '0;
	assign o_pready  = 1'b1;
	assign o_pslverr = access & err;
	assign o_irq     = r_done;

	// ------------------------------------------------------------
	// Control and status
	// ------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_ks_start <= 1'b0;
			o_din_en   <= 1'b0;
			o_dir      <= rc6_pkg::DIR_DECRYPT;
			r_ks_run   <= 1'b0;
			r_busy     <= 1'b0;
			r_done     <= 1'b0;
		end else begin
			// Start pulses one cycle after the write
			o_ks_start <= wr_en & (reg_sel == rc6_pkg::REG_CTRL) & i_pwdata[0];
			o_din_en   <= wr_en & (reg_sel == rc6_pkg::REG_CTRL) & i_pwdata[1];
			if (wr_en && reg_sel == rc6_pkg::REG_CTRL)
				o_dir <= rc6_pkg::rc6_dir_e'(i_pwdata[2]);
			if (o_ks_start)
				r_ks_run <= 1'b1;
			else if (i_key_ready)
				r_ks_run <= 1'b0;
			if (i_dout_en)
				r_busy <= 1'b0;
			else if (wr_en && reg_sel == rc6_pkg::REG_CTRL && i_pwdata[1])
				r_busy <= 1'b1;
			// Completion wins over a STATUS read in the same cycle
			if (i_dout_en)
				r_done <= 1'b1;
			else if (rd_status)
				r_done <= 1'b0;
		end
	end

	// Key, data in and data out words
	always_ff @(posedge i_clk) begin
		if (wr_en && key_hit && reg_sel inside {rc6_pkg::REG_KEY0, rc6_pkg::REG_KEY1,
				rc6_pkg::REG_KEY2, rc6_pkg::REG_KEY3, rc6_pkg::REG_KEY4,
				rc6_pkg::REG_KEY5, rc6_pkg::REG_KEY6, rc6_pkg::REG_KEY7})
			r_key[key_idx[KIW-1:0]] <= i_pwdata;
		if (wr_en && reg_sel inside {rc6_pkg::REG_DIN0, rc6_pkg::REG_DIN1,
				rc6_pkg::REG_DIN2, rc6_pkg::REG_DIN3})
			r_din[i_paddr[3:2]] <= i_pwdata;
		if (i_dout_en)
			r_dout <= i_dout;
	end

	// Key register j is L[j]
	for (genvar j = 0; j < KEY_WORDS; j++) begin : g_user_key
		assign o_user_key[32*j +: 32] = r_key[j];
	end

	assign o_din = {r_din[0], r_din[1], r_din[2], r_din[3]};

	// APB protocol and start exclusivity
	a_penable_psel: assert property (@(posedge i_clk) disable iff (i_rst)
		i_penable |-> i_psel);
	a_start_excl: assert property (@(posedge i_clk) disable iff (i_rst)
		!(o_din_en && o_ks_start));

endmodule

//--- source/rc6_key_sched.sv
// RC6 key schedule stage
// Sequential expansion of the user key into the round-key words

module rc6_key_sched #(
	parameter int KEY_WORDS = 4
) (
	input  logic                                i_clk,
	input  logic                                i_rst,
	input  logic                                i_start,
	input  logic [32*KEY_WORDS-1:0]             i_user_key,
	output logic [32*rc6_pkg::NUM_SUBKEYS-1:0]  o_keyex,
	output logic                                o_key_ready
);

	localparam int NSK       = rc6_pkg::NUM_SUBKEYS;
	// Three passes over the longer of the two arrays
	localparam int MIX_STEPS = 3 * ((KEY_WORDS > NSK) ? KEY_WORDS : NSK);
	localparam int STW       = $clog2(MIX_STEPS);
	localparam int LIW       = (KEY_WORDS > 1) ? $clog2(KEY_WORDS) : 1;

	rc6_pkg::ks_state_e r_state;
	logic [STW-1:0]     r_step;
	logic [5:0]         r_si;
	logic [LIW-1:0]     r_li;
	logic [31:0]        r_s [NSK];
	logic [31:0]        r_l [KEY_WORDS];
	logic [31:0]        r_a;
	logic [31:0]        r_b;
	logic [31:0]        mix_a;
	logic [31:0]        mix_ab;
	logic [31:0]        mix_b;
	logic               last_step;

	// ------------------------------------------------------------
	// One mixing step
	// ------------------------------------------------------------
	// A = S[i] = ROL(S[i] + A + B, 3)
	assign mix_a  = rc6_pkg::rc6_rol(r_s[r_si] + r_a + r_b, 5'd3);
	// B = L[j] = ROL(L[j] + A + B, A + B), new A
	assign mix_ab = mix_a + r_b;
	assign mix_b  = rc6_pkg::rc6_rol(r_l[r_li] + mix_ab, mix_ab[4:0]);

	assign last_step = (r_step == STW'(MIX_STEPS - 1));

	// Control FSM
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state <= rc6_pkg::KS_IDLE;
			r_step  <= '0;
			r_si    <= '0;
			r_li    <= '0;
		end else if (i_start) begin
			r_state <= rc6_pkg::KS_MIX;
			r_step  <= '0;
			r_si    <= '0;
			r_li    <= '0;
		end else begin
			case (r_state)
				rc6_pkg::KS_MIX: begin
					r_step <= r_step + 1'b1;
					// i mod 44, j mod KEY_WORDS
					r_si   <= (r_si == 6'(NSK - 1)) ? 6'd0 : r_si + 6'd1;
					r_li   <= (r_li == LIW'(KEY_WORDS - 1)) ? '0 : r_li + 1'b1;
					if (last_step)
						r_state <= rc6_pkg::KS_READY;
				end
				rc6_pkg::KS_READY:
					r_state <= rc6_pkg::KS_READY;
				default:
					r_state <= rc6_pkg::KS_IDLE;
			endcase
		end
	end

	// S, L and the running A and B
	always_ff @(posedge i_clk) begin
		if (i_start) begin
			// S[k] = P32 + k * Q32
			for (int k = 0; k < NSK; k++)
				r_s[k] <= rc6_pkg::RC6_P32 + 32'(k) * rc6_pkg::RC6_Q32;
			for (int k = 0; k < KEY_WORDS; k++)
				r_l[k] <= i_user_key[32*k +: 32];
			r_a <= '0;
			r_b <= '0;
		end else if (r_state == rc6_pkg::KS_MIX) begin
			r_s[r_si] <= mix_a;
			r_l[r_li] <= mix_b;
			r_a       <= mix_a;
			r_b       <= mix_b;
		end
	end

	// Word 0 at the least significant end
	for (genvar k = 0; k < NSK; k++) begin : g_keyex
		assign o_keyex[32*k +: 32] = r_s[k];
	end

	assign o_key_ready = (r_state == rc6_pkg::KS_READY);

	// Register stage must hold back starts during expansion
	a_no_start_in_mix: assert property (@(posedge i_clk) disable iff (i_rst)
		(r_state == rc6_pkg::KS_MIX) |-> !i_start);

endmodule

//--- source/rc6_dpc.sv
// RC6 round stage
// Iterative 20-round encrypt and decrypt core with pre and post whitening

module rc6_dpc (
	input  logic                                i_clk,
	input  logic                                i_rst,
	input  rc6_pkg::rc6_dir_e                   i_dir,
	input  logic [32*rc6_pkg::NUM_SUBKEYS-1:0]  i_keyex,
	input  logic [127:0]                        i_din,
	input  logic                                i_din_en,
	output logic [127:0]                        o_dout,
	output logic                                o_dout_en
);

	localparam int NSK  = rc6_pkg::NUM_SUBKEYS;
	// Round keys for rounds 2..20 in either direction
	localparam int RK_W = 32 * (NSK - 6);

	logic [31:0]        s_key [NSK];
	logic [4:0]         r_count;
	logic [RK_W-1:0]    r_rk;
	logic [127:0]       r_st;
	rc6_pkg::rc6_dir_e  r_dir;
	logic               enc;
	logic [31:0]        ia, ib, ic, id;
	logic [127:0]       pre;
	logic [127:0]       st;
	logic [31:0]        a, b, c, d;
	logic [31:0]        rk_lo, rk_hi;
	logic [31:0]        t, u;
	logic [31:0]        x_in, y_in;
	logic [4:0]         x_amt, y_amt;
	logic [31:0]        x_rot, y_rot;
	logic [127:0]       nxt;
	logic [31:0]        na, nb, nc, nd;

	for (genvar k = 0; k < NSK; k++) begin : g_key
		assign s_key[k] = i_keyex[32*k +: 32];
	end

	// Direction is taken from the port only on the start cycle
	assign enc = ((i_din_en ? i_dir : r_dir) == rc6_pkg::DIR_ENCRYPT);

	// ------------------------------------------------------------
	// Input swap and pre-whitening
	// ------------------------------------------------------------
	assign ia = rc6_pkg::rc6_byteswap(i_din[127:96]);
	assign ib = rc6_pkg::rc6_byteswap(i_din[95:64]);
	assign ic = rc6_pkg::rc6_byteswap(i_din[63:32]);
	assign id = rc6_pkg::rc6_byteswap(i_din[31:0]);

	// Encrypt adds S[0], S[1]; decrypt removes S[42], S[43]
	assign pre = enc ? {ia, ib + s_key[0], ic, id + s_key[1]}
		: {ia - s_key[NSK-2], ib, ic - s_key[NSK-1], id};

	assign st = i_din_en ? pre : r_st;

	// Decrypt rotates (A,B,C,D) = (D,A,B,C) before the round
	assign {a, b, c, d} = enc ? st : {st[31:0], st[127:32]};

	// Round keys S[2r], S[2r+1]
	always_comb begin
		if (i_din_en) begin
			rk_lo = enc ? s_key[2] : s_key[NSK-4];
			rk_hi = enc ? s_key[3] : s_key[NSK-3];
		end else begin
			rk_lo = enc ? r_rk[31:0] : r_rk[RK_W-33 -: 32];
			rk_hi = enc ? r_rk[63:32] : r_rk[RK_W-1 -: 32];
		end
	end

	// ------------------------------------------------------------
	// Round function
	// ------------------------------------------------------------
	assign t = rc6_pkg::rc6_rol(b * ((b << 1) + 32'd1), 5'd5);
	assign u = rc6_pkg::rc6_rol(d * ((d << 1) + 32'd1), 5'd5);

	// Right rotate done as left rotate by the negated amount
	assign x_in  = enc ? (a ^ t) : (c - rk_hi);
	assign x_amt = enc ? u[4:0] : (5'd0 - t[4:0]);
	assign y_in  = enc ? (c ^ u) : (a - rk_lo);
	assign y_amt = enc ? t[4:0] : (5'd0 - u[4:0]);
	assign x_rot = rc6_pkg::rc6_rol(x_in, x_amt);
	assign y_rot = rc6_pkg::rc6_rol(y_in, y_amt);

	// Encrypt rotates (A,B,C,D) = (B,C,D,A) after the round
	assign nxt = enc ? {b, y_rot + rk_hi, d, x_rot + rk_lo}
		: {y_rot ^ t, b, x_rot ^ u, d};

	assign {na, nb, nc, nd} = nxt;

	// Post-whitening on the last round result
	assign o_dout = enc
		? {rc6_pkg::rc6_byteswap(na + s_key[NSK-2]), rc6_pkg::rc6_byteswap(nb),
			rc6_pkg::rc6_byteswap(nc + s_key[NSK-1]), rc6_pkg::rc6_byteswap(nd)}
		: {rc6_pkg::rc6_byteswap(na), rc6_pkg::rc6_byteswap(nb - s_key[0]),
			rc6_pkg::rc6_byteswap(nc), rc6_pkg::rc6_byteswap(nd - s_key[1])};

	assign o_dout_en = (r_count == 5'(rc6_pkg::NUM_ROUNDS - 1));

	// Round counter is 0 when idle
	always_ff @(posedge i_clk) begin
		if (i_rst)
			r_count <= 5'd0;
		else if (i_din_en)
			r_count <= 5'd1;
		else if (o_dout_en)
			r_count <= 5'd0;
		else if (r_count != 5'd0)
			r_count <= r_count + 5'd1;
	end

	// State, direction and round-key shifter
	always_ff @(posedge i_clk) begin
		if (i_din_en) begin
			r_dir <= i_dir;
			r_rk  <= (i_dir == rc6_pkg::DIR_ENCRYPT) ? i_keyex[32*4 +: RK_W]
				: i_keyex[32*2 +: RK_W];
		end else if (r_count != 5'd0) begin
			// Encrypt walks forward, decrypt backward
			r_rk <= enc ? {64'd0, r_rk[RK_W-1:64]} : {r_rk[RK_W-65:0], 64'd0};
		end
		if (i_din_en || r_count != 5'd0)
			r_st <= nxt;
	end

	// One block in flight
	a_no_restart: assert property (@(posedge i_clk) disable iff (i_rst)
		(r_count != 5'd0) |-> !i_din_en);

endmodule

//--- source/rc6_top.sv
// RC6 APB peripheral top level
// Register stage, key schedule stage and round stage in a chain

module rc6_top #(
	parameter int KEY_WORDS = 4
) (
	input  logic         i_clk,
	input  logic         i_rst,
	input  logic         i_psel,
	input  logic         i_penable,
	input  logic         i_pwrite,
	input  logic [7:0]   i_paddr,
	input  logic [31:0]  i_pwdata,
	output logic [31:0]  o_prdata,
	output logic         o_pready,
	output logic         o_pslverr,
	output logic         o_irq
);

	localparam int KEYEX_W = 32 * rc6_pkg::NUM_SUBKEYS;

	// Register stage to key schedule
	logic                     ks_start;
	logic [32*KEY_WORDS-1:0]  user_key;
	logic                     key_ready;
	logic [KEYEX_W-1:0]       keyex;
	// Register stage to round stage
	logic                     din_en;
	logic [127:0]             din;
	rc6_pkg::rc6_dir_e        dir;
	logic [127:0]             dout;
	logic                     dout_en;

	rc6_apb_regs #(
		.KEY_WORDS (KEY_WORDS)
	) u_regs (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_psel      (i_psel),
		.i_penable   (i_penable),
		.i_pwrite    (i_pwrite),
		.i_paddr     (i_paddr),
		.i_pwdata    (i_pwdata),
		.o_prdata    (o_prdata),
		.o_pready    (o_pready),
		.o_pslverr   (o_pslverr),
		.o_irq       (o_irq),
		.o_ks_start  (ks_start),
		.o_user_key  (user_key),
		.i_key_ready (key_ready),
		.o_din_en    (din_en),
		.o_din       (din),
		.o_dir       (dir),
		.i_dout      (dout),
		.i_dout_en   (dout_en)
	);

	rc6_key_sched #(
		.KEY_WORDS (KEY_WORDS)
	) u_ks (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_start     (ks_start),
		.i_user_key  (user_key),
		.o_keyex     (keyex),
		.o_key_ready (key_ready)
	);

	rc6_dpc u_dpc (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_dir     (dir),
		.i_keyex   (keyex),
		.i_din     (din),
		.i_din_en  (din_en),
		.o_dout    (dout),
		.o_dout_en (dout_en)
	);

endmodule

//--- test/tb_clkgen.sv
// Testbench clock and synchronous reset generator

module tb_clkgen #(
	parameter int PERIOD     = 100,
	parameter int RST_CYCLES = 3
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD / 2) o_clk = ~o_clk;
	end

	// Reset released shortly after the last reset edge
	initial begin
		o_rst = 1'b1;
		repeat (RST_CYCLES) @(posedge o_clk);
		#1 o_rst = 1'b0;
	end

endmodule

//--- test/tb_rc6.sv
// Testbench for the RC6 APB peripheral
// APB driver tasks, xorshift generator, behavioral RC6 model, stimulus and checks

module tb_rc6;

	localparam int DLY = 10;
	localparam logic ENC = 1'b1;
	localparam logic DEC = 1'b0;
	// Published RC6 vector for a zero key and zero plaintext
	localparam logic [127:0] KAT_CT = 128'h8fc3a536_56b1f778_c129df4e_9848a41e;

	logic clk, rst, psel, penable, pwrite, pready, pslverr, irq;
	logic [7:0]  paddr;
	logic [31:0] pwdata, prdata;
	logic [31:0] rng_state = 32'ha4f811f1;
	logic [31:0] sk [44];
	logic [31:0] key [4];
	logic [127:0] pt, ct, res, dout_ref;
	int cnt;

	tb_clkgen #(.PERIOD(100), .RST_CYCLES(3)) u_clkgen (.o_clk(clk), .o_rst(rst));

	rc6_top #(.KEY_WORDS(4)) dut (
		.i_clk(clk), .i_rst(rst), .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
		.i_paddr(paddr), .i_pwdata(pwdata), .o_prdata(prdata), .o_pready(pready),
		.o_pslverr(pslverr), .o_irq(irq)
	);

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [127:0] exp,
			input logic [127:0] act);
		assert (act === exp)
			else stop_with_error(
				$sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	// ------------------------------------------------------------
	// Bus level checks
	// ------------------------------------------------------------
	pready_high: assert property (@(posedge clk) disable iff (rst) pready)
		else stop_with_error("PREADY went low");
	pslverr_in_access: assert property (@(posedge clk) disable iff (rst)
		pslverr |-> (psel && penable))
		else stop_with_error("PSLVERR raised outside an access phase");
	// Interrupt rises 21 cycles after the accepted block start in cycle N
	irq_timing: assert property (@(posedge clk) disable iff (rst)
		(psel && penable && pwrite && paddr == 8'h00 && pwdata[1] && !pslverr)
		|-> ##20 !irq ##1 irq)
		else stop_with_error("interrupt did not rise 21 cycles after the block start");

	// ------------------------------------------------------------
	// RC6 reference model on little-endian cipher words
	// ------------------------------------------------------------
	function automatic logic [31:0] rotl(input logic [31:0] x, input logic [31:0] n);
		logic [4:0] r;
		r = n[4:0];
		return (r == 0) ? x : ((x << r) | (x >> (32 - r)));
	endfunction

	function automatic logic [31:0] swap_bytes(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic expand_model(input logic [31:0] k_in [4]);
		logic [31:0] l [4];
		logic [31:0] a, b;
		int i, j;
		l = k_in;
		sk[0] = 32'hB7E15163;
		for (int k = 1; k < 44; k++)
			sk[k] = sk[k-1] + 32'h9E3779B9;
		a = 0;
		b = 0;
		i = 0;
		j = 0;
		// 3 * max(4, 44) mixing steps
		for (int s = 0; s < 132; s++) begin
			a = rotl(sk[i] + a + b, 3);
			sk[i] = a;
			b = rotl(l[j] + a + b, a + b);
			l[j] = b;
			i = (i + 1) % 44;
			j = (j + 1) % 4;
		end
	endtask

	function automatic logic [127:0] model_cipher(input logic dir, input logic [127:0] blk);
		logic [31:0] a, b, c, d, t, u, tmp;
		a = swap_bytes(blk[127:96]);
		b = swap_bytes(blk[95:64]);
		c = swap_bytes(blk[63:32]);
		d = swap_bytes(blk[31:0]);
		if (dir == ENC) begin
			b = b + sk[0];
			d = d + sk[1];
			for (int r = 1; r <= 20; r++) begin
				t = rotl(b * (2 * b + 1), 5);
				u = rotl(d * (2 * d + 1), 5);
				a = rotl(a ^ t, u) + sk[2*r];
				c = rotl(c ^ u, t) + sk[2*r+1];
				tmp = a;
				a = b;
				b = c;
				c = d;
				d = tmp;
			end
			a = a + sk[42];
			c = c + sk[43];
		end else begin
			c = c - sk[43];
			a = a - sk[42];
			for (int r = 20; r >= 1; r--) begin
				tmp = d;
				d = c;
				c = b;
				b = a;
				a = tmp;
				u = rotl(d * (2 * d + 1), 5);
				t = rotl(b * (2 * b + 1), 5);
				// Right rotate as left by 32 - n
				c = rotl(c - sk[2*r+1], 32 - t) ^ u;
				a = rotl(a - sk[2*r], 32 - u) ^ t;
			end
			d = d - sk[1];
			b = b - sk[0];
		end
		return {swap_bytes(a), swap_bytes(b), swap_bytes(c), swap_bytes(d)};
	endfunction

	// ------------------------------------------------------------
	// APB driver with two cycles per transfer
	// ------------------------------------------------------------
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
			output logic [31:0] rdata, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#DLY penable = 1'b1;
		// Access phase outputs sampled mid-cycle
		@(negedge clk);
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		#DLY psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input string name, input logic [7:0] addr, input logic [31:0] data,
			input logic exp_err);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b1, addr, data, rd, err);
		check_value({name, "_pslverr"}, exp_err, err);
	endtask

	task automatic apb_read(input string name, input logic [7:0] addr, output logic [31:0] data);
		logic err;
		apb_xfer(1'b0, addr, 32'd0, data, err);
		check_value({name, "_pslverr"}, 1'b0, err);
	endtask

	// ------------------------------------------------------------
	// Peripheral level sequences
	// ------------------------------------------------------------
	task automatic wait_status_bit(input int bit_idx, input int limit, input string what);
		logic [31:0] st;
		int n;
		n = 0;
		st = '0;
		while (!st[bit_idx]) begin
			if (n == limit)
				stop_with_error({"timeout waiting for ", what});
			apb_read("status_poll", 8'h04, st);
			n++;
		end
	endtask

	task automatic load_key(input logic [31:0] k_in [4]);
		for (int k = 0; k < 4; k++)
			apb_write("key", 8'h10 + 8'(4 * k), k_in[k], 1'b0);
		apb_write("key_start", 8'h00, 32'h1, 1'b0);
		expand_model(k_in);
		wait_status_bit(0, 400, "key_ready");
	endtask

	task automatic read_dout(output logic [127:0] blk);
		logic [31:0] w;
		for (int k = 0; k < 4; k++) begin
			apb_read("dout", 8'h40 + 8'(4 * k), w);
			blk[32*(3-k) +: 32] = w;
		end
	endtask

	task automatic start_block(input logic dir, input logic [127:0] blk);
		for (int k = 0; k < 4; k++)
			apb_write("din", 8'h30 + 8'(4 * k), blk[32*(3-k) +: 32], 1'b0);
		apb_write("block_start", 8'h00, {29'd0, dir, 2'b10}, 1'b0);
	endtask

	task automatic run_block(input logic dir, input logic [127:0] blk, output logic [127:0] out);
		start_block(dir, blk);
		// STATUS poll for done also clears it
		wait_status_bit(2, 40, "block done");
		read_dout(out);
	endtask

	task automatic refused(input string name, input logic wr, input logic [7:0] addr,
			input logic [31:0] data, input logic [127:0] exp_dout, input logic [31:0] exp_st);
		logic [31:0] rd;
		logic err;
		logic [127:0] d;
		apb_xfer(wr, addr, data, rd, err);
		check_value({name, "_pslverr"}, 1'b1, err);
		read_dout(d);
		check_value({name, "_dout"}, exp_dout, d);
		apb_read("status", 8'h04, rd);
		check_value({name, "_status"}, exp_st, rd);
	endtask

	function automatic void random_key();
		for (int k = 0; k < 4; k++)
			key[k] = next_random();
	endfunction

	function automatic logic [127:0] random_block();
		return {next_random(), next_random(), next_random(), next_random()};
	endfunction

	initial begin
		logic [31:0] st;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h00;
		pwdata = 32'h0;
		cnt = 0;
		while (rst !== 1'b0) begin
			if (cnt == 20)
				stop_with_error("reset never released");
			@(posedge clk);
			cnt++;
		end
		#DLY;

		// Reset state
		apb_read("status", 8'h04, st);
		check_value("reset_status", 32'h0, st);
		check_value("reset_irq", 1'b0, irq);

		// Known answer on the model and the DUT
		for (int k = 0; k < 4; k++)
			key[k] = 32'h0;
		load_key(key);
		check_value("kat_model", KAT_CT, model_cipher(ENC, 128'h0));
		run_block(ENC, 128'h0, res);
		check_value("kat_dut", KAT_CT, res);

		// Random encrypt, decrypt round trip and random decrypt
		for (int n = 0; n < 8; n++) begin
			random_key();
			load_key(key);
			pt = random_block();
			run_block(ENC, pt, ct);
			check_value($sformatf("encrypt_%0d", n), model_cipher(ENC, pt), ct);
			run_block(DEC, ct, res);
			check_value($sformatf("roundtrip_%0d", n), pt, res);
			pt = random_block();
			run_block(DEC, pt, res);
			check_value($sformatf("decrypt_%0d", n), model_cipher(DEC, pt), res);
		end

		// Interrupt timing and clear on STATUS read
		pt = random_block();
		start_block(ENC, pt);
		cnt = 0;
		while (!irq) begin
			if (cnt == 30)
				stop_with_error("timeout waiting for o_irq");
			@(posedge clk);
			#DLY;
			cnt++;
		end
		check_value("irq_cycle", 20, cnt);
		apb_read("status", 8'h04, st);
		check_value("irq_status", 32'h5, st);
		check_value("irq_cleared", 1'b0, irq);
		read_dout(dout_ref);
		check_value("irq_dout", model_cipher(ENC, pt), dout_ref);

		// Refused accesses leave DOUT and STATUS alone
		refused("unmapped", 1'b0, 8'h50, 32'h0, dout_ref, 32'h1);
		refused("dout_write", 1'b1, 8'h40, 32'hdeadbeef, dout_ref, 32'h1);
		apb_write("key_start", 8'h00, 32'h1, 1'b0);
		refused("start_no_key", 1'b1, 8'h00, 32'h6, dout_ref, 32'h0);
		wait_status_bit(0, 400, "key_ready");
		pt = random_block();
		start_block(ENC, pt);
		refused("start_busy", 1'b1, 8'h00, 32'h6, dout_ref, 32'h3);
		wait_status_bit(2, 40, "block done");
		read_dout(res);
		check_value("busy_block", model_cipher(ENC, pt), res);

		// New key after a completed block
		random_key();
		for (int k = 0; k < 4; k++)
			apb_write("key", 8'h10 + 8'(4 * k), key[k], 1'b0);
		apb_write("key_start", 8'h00, 32'h1, 1'b0);
		apb_read("status", 8'h04, st);
		check_value("rekey_status", 32'h0, st);
		expand_model(key);
		wait_status_bit(0, 400, "key_ready");
		pt = random_block();
		run_block(ENC, pt, res);
		check_value("rekey_encrypt", model_cipher(ENC, pt), res);

		$display("Testbench passed");
		$finish;
	end

endmodule

//--- tb.f
source/rc6_pkg.sv
source/rc6_apb_regs.sv
source/rc6_key_sched.sv
source/rc6_dpc.sv
source/rc6_top.sv
test/tb_clkgen.sv
test/tb_rc6.sv
